// ==== verilog/dcache_pkg.sv ====
/*
 * Shared widths, vector types and structs for the replay-queued data cache.
 * Modules import this package inside their bodies.
 */
`default_nettype none

package dcache_pkg;

   // Address split inside a block
   localparam int byte_off_w_gp  = 2;
   localparam int word_sel_w_gp  = 2;
   localparam int block_off_w_gp = byte_off_w_gp + word_sel_w_gp;

   typedef logic [31:0]  word_t;
   typedef logic [11:0]  page_offset_t;
   typedef logic [19:0]  ptag_t;
   typedef logic [31:0]  paddr_t;
   typedef logic [127:0] block_t;

   typedef enum logic
   {
      e_op_load
     ,e_op_store
   } dcache_op_e;

   typedef struct packed
   {
      dcache_op_e   opcode;
      page_offset_t offset;
      word_t        data;
   } dcache_pkt_t;

   // One replay queue entry, request plus its physical tag
   typedef struct packed
   {
      dcache_pkt_t pkt;
      ptag_t       ptag;
   } rolly_entry_t;

   typedef enum logic
   {
      e_mem_read
     ,e_mem_write
   } mem_op_e;

   typedef struct packed
   {
      mem_op_e op;
      paddr_t  addr;
      word_t   data;
   } mem_cmd_t;

   typedef struct packed
   {
      block_t data;
   } mem_resp_t;

   typedef struct packed
   {
      mem_op_e op;
      paddr_t  addr;
      word_t   data;
   } miss_req_t;

   typedef struct packed
   {
      paddr_t addr;
      block_t data;
   } fill_t;

endpackage

`default_nettype wire

// ==== verilog/replay_fifo.sv ====
/*
 * Request queue that holds entries until the cache returns their result.
 * A missing result two cycles after issue rolls the read pointer back.
 */
`timescale 1ns/1ps
`default_nettype none

module replay_fifo
   #(parameter fifo_els_p = 8)
   (input  logic                     clk_i
   ,input  logic                     rst_i

   ,input  dcache_pkg::rolly_entry_t entry_i
   ,input  logic                     v_i
   ,output logic                     ready_o

   ,output dcache_pkg::rolly_entry_t entry_o
   ,output logic                     issue_o
   ,input  logic                     commit_i
   ,output logic                     flush_o
   );

   import dcache_pkg::*;

   localparam int ptr_w_lp = $clog2(fifo_els_p);

   // Extra top bit tells a full queue from an empty one
   typedef logic [ptr_w_lp:0] ptr_t;

   rolly_entry_t mem_r [fifo_els_p];

   ptr_t wptr_r;
   ptr_t rptr_r;
   ptr_t cptr_r;
   ptr_t held;

   logic [1:0] watch_r;
   logic       enq;
   logic       unissued;
   logic       rollback;

   assign held     = wptr_r - cptr_r;
   assign ready_o  = (held != ptr_t'(fifo_els_p));
   assign enq      = v_i & ready_o;
   assign unissued = (rptr_r != wptr_r);

   // Entry issued two cycles ago came back without a result
   assign rollback = watch_r[1] & ~commit_i;

   assign issue_o = unissued & ~rollback;
   assign flush_o = rollback;
   assign entry_o = mem_r[rptr_r[ptr_w_lp-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (enq)
         mem_r[wptr_r[ptr_w_lp-1:0]] <= entry_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         cptr_r  <= '0;
         watch_r <= '0;
      end
      else
      begin
         if (enq)
            wptr_r <= wptr_r + 1'b1;

         if (rollback)
            rptr_r <= cptr_r;
         else if (issue_o)
            rptr_r <= rptr_r + 1'b1;

         if (commit_i)
            cptr_r <= cptr_r + 1'b1;

         // Younger issue in stage 1 is flushed along with the rollback
         watch_r <= {watch_r[0] & ~rollback, issue_o};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/dcache_pipe.sv ====
/*
 * Direct mapped write-through data cache, two stages deep.
 * Stage 1 reads the arrays, stage 2 compares tags and raises misses.
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_pipe
   #(parameter sets_p = 16)
   (input  logic                     clk_i
   ,input  logic                     rst_i

   ,input  dcache_pkg::rolly_entry_t entry_i
   ,input  logic                     issue_i
   ,input  logic                     flush_i

   ,output dcache_pkg::word_t        data_o
   ,output logic                     v_o

   ,output dcache_pkg::miss_req_t    miss_o
   ,output logic                     miss_v_o
   ,input  logic                     miss_busy_i

   ,input  dcache_pkg::fill_t        fill_i
   ,input  logic                     fill_v_i
   );

   import dcache_pkg::*;

   localparam int idx_w_lp = $clog2(sets_p);
   localparam int tag_w_lp = $bits(paddr_t) - block_off_w_gp - idx_w_lp;

   typedef logic [idx_w_lp-1:0] idx_t;
   typedef logic [tag_w_lp-1:0] tag_t;

   tag_t              tag_mem_r  [sets_p];
   block_t            data_mem_r [sets_p];
   logic [sets_p-1:0] valid_r;

   logic         s1_v_r;
   rolly_entry_t s1_entry_r;
   paddr_t       s1_paddr;
   idx_t         s1_idx;

   logic         s2_v_r;
   rolly_entry_t s2_entry_r;
   tag_t         s2_tag_r;
   logic         s2_valid_r;
   block_t       s2_block_r;
   paddr_t       s2_paddr;
   idx_t         s2_idx;
   tag_t         s2_tag;

   logic [word_sel_w_gp-1:0] s2_word;
   logic                     s2_hit;
   logic                     s2_store;
   logic                     store_done;
   block_t                   store_block;

   logic   wr_en;
   idx_t   wr_idx;
   tag_t   wr_tag;
   block_t wr_block;

   assign s1_paddr = {s1_entry_r.ptag, s1_entry_r.pkt.offset};
   assign s1_idx   = s1_paddr[block_off_w_gp +: idx_w_lp];

   assign s2_paddr = {s2_entry_r.ptag, s2_entry_r.pkt.offset};
   assign s2_idx   = s2_paddr[block_off_w_gp +: idx_w_lp];
   assign s2_tag   = s2_paddr[$bits(paddr_t)-1 -: tag_w_lp];
   assign s2_word  = s2_paddr[byte_off_w_gp +: word_sel_w_gp];

   assign s2_hit     = s2_v_r & s2_valid_r & (s2_tag_r == s2_tag);
   assign s2_store   = (s2_entry_r.pkt.opcode == e_op_store);
   assign store_done = s2_hit & s2_store & ~miss_busy_i;

   assign v_o    = (s2_hit & ~s2_store) | store_done;
   assign data_o = s2_store ? '0 : s2_block_r[s2_word*$bits(word_t) +: $bits(word_t)];

   // Misses fetch the block, store hits write through
   assign miss_v_o = s2_v_r & ~miss_busy_i & (~s2_hit | s2_store);
   assign miss_o   = '{op:   s2_hit ? e_mem_write : e_mem_read
                      ,addr: s2_paddr
                      ,data: s2_entry_r.pkt.data};

   always_comb
   begin
      store_block = s2_block_r;
      store_block[s2_word*$bits(word_t) +: $bits(word_t)] = s2_entry_r.pkt.data;
   end

   // Fills and store hits never coincide, the miss unit is busy during a fill
   always_comb
   begin
      wr_en = fill_v_i | store_done;
      if (fill_v_i)
      begin
         wr_idx   = fill_i.addr[block_off_w_gp +: idx_w_lp];
         wr_tag   = fill_i.addr[$bits(paddr_t)-1 -: tag_w_lp];
         wr_block = fill_i.data;
      end
      else
      begin
         wr_idx   = s2_idx;
         wr_tag   = s2_tag;
         wr_block = store_block;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         tag_mem_r[wr_idx]  <= wr_tag;
         data_mem_r[wr_idx] <= wr_block;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         valid_r <= '0;
      else if (wr_en)
         valid_r[wr_idx] <= 1'b1;
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         s1_v_r <= 1'b0;
         s2_v_r <= 1'b0;
      end
      else
      begin
         s1_v_r <= issue_i;
         s2_v_r <= s1_v_r & ~flush_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      s1_entry_r <= entry_i;
      s2_entry_r <= s1_entry_r;
      // Bypass a write landing on the set stage 1 reads this cycle
      if (wr_en && (wr_idx == s1_idx))
      begin
         s2_tag_r   <= wr_tag;
         s2_valid_r <= 1'b1;
         s2_block_r <= wr_block;
      end
      else
      begin
         s2_tag_r   <= tag_mem_r[s1_idx];
         s2_valid_r <= valid_r[s1_idx];
         s2_block_r <= data_mem_r[s1_idx];
      end
   end

endmodule

`default_nettype wire

// ==== verilog/miss_unit.sv ====
/*
 * Miss handler between the cache pipe and memory.
 * Sends block reads and write-through stores, then fills the arrays.
 */
`timescale 1ns/1ps
`default_nettype none

module miss_unit
   (input  logic                  clk_i
   ,input  logic                  rst_i

   ,input  dcache_pkg::miss_req_t miss_i
   ,input  logic                  miss_v_i
   ,output logic                  miss_busy_o

   ,output dcache_pkg::mem_cmd_t  mem_cmd_o
   ,output logic                  mem_cmd_v_o
   ,input  logic                  mem_cmd_ready_i

   ,input  dcache_pkg::mem_resp_t mem_resp_i
   ,input  logic                  mem_resp_v_i
   ,output logic                  mem_resp_yumi_o

   ,output dcache_pkg::fill_t     fill_o
   ,output logic                  fill_v_o
   );

   import dcache_pkg::*;

   typedef enum logic [1:0]
   {
      e_idle
     ,e_send
     ,e_wait_resp
     ,e_fill
   } state_e;

   state_e    state_r;
   state_e    state_n;
   miss_req_t req_r;
   block_t    resp_block_r;
   paddr_t    block_addr;
   logic      is_read;

   assign is_read    = (req_r.op == e_mem_read);
   assign block_addr = {req_r.addr[$bits(paddr_t)-1:block_off_w_gp], {block_off_w_gp{1'b0}}};

   assign miss_busy_o     = (state_r != e_idle);
   assign mem_cmd_v_o     = (state_r == e_send);
   assign mem_resp_yumi_o = (state_r == e_wait_resp) & mem_resp_v_i;
   assign fill_v_o        = (state_r == e_fill);

   // Built from latched state only, so it holds while memory stalls
   assign mem_cmd_o = '{op:   req_r.op
                       ,addr: is_read ? block_addr : req_r.addr
                       ,data: req_r.data};

   assign fill_o = '{addr: block_addr, data: resp_block_r};

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         e_idle:
            if (miss_v_i)
               state_n = e_send;
         e_send:
            if (mem_cmd_ready_i)
               state_n = is_read ? e_wait_resp : e_idle;
         e_wait_resp:
            if (mem_resp_v_i)
               state_n = e_fill;
         e_fill:
            state_n = e_idle;
         default:
            state_n = e_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         state_r <= e_idle;
      else
         state_r <= state_n;
   end

   always_ff @(posedge clk_i)
   begin
      if ((state_r == e_idle) && miss_v_i)
         req_r <= miss_i;
      if (mem_resp_yumi_o)
         resp_block_r <= mem_resp_i.data;
   end

endmodule

`default_nettype wire

// ==== verilog/dcache_replay_top.sv ====
/*
 * Data cache with a replay queue in front and a miss unit behind.
 * Requests go in order, one result pulse per request on v_o.
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_replay_top
   #(parameter fifo_els_p = 8
    ,parameter sets_p     = 16
    )
   (input  logic                    clk_i
   ,input  logic                    rst_i

   ,input  dcache_pkg::dcache_pkt_t pkt_i
   ,input  dcache_pkg::ptag_t       ptag_i
   ,input  logic                    v_i
   ,output logic                    ready_o

   ,output dcache_pkg::word_t       data_o
   ,output logic                    v_o

   ,output dcache_pkg::mem_cmd_t    mem_cmd_o
   ,output logic                    mem_cmd_v_o
   ,input  logic                    mem_cmd_ready_i

   ,input  dcache_pkg::mem_resp_t   mem_resp_i
   ,input  logic                    mem_resp_v_i
   ,output logic                    mem_resp_yumi_o
   );

   import dcache_pkg::*;

   rolly_entry_t entry_li;
   rolly_entry_t rolly_entry_lo;
   logic         rolly_issue_lo;
   logic         flush_lo;
   logic         pipe_v_lo;

   miss_req_t    miss_lo;
   logic         miss_v_lo;
   logic         miss_busy_lo;
   fill_t        fill_lo;
   logic         fill_v_lo;

   assign entry_li = '{pkt: pkt_i, ptag: ptag_i};

   replay_fifo
      #(.fifo_els_p(fifo_els_p))
      rolly
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.entry_i(entry_li)
      ,.v_i(v_i)
      ,.ready_o(ready_o)
      ,.entry_o(rolly_entry_lo)
      ,.issue_o(rolly_issue_lo)
      ,.commit_i(pipe_v_lo)
      ,.flush_o(flush_lo)
      );

   dcache_pipe
      #(.sets_p(sets_p))
      dcache
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.entry_i(rolly_entry_lo)
      ,.issue_i(rolly_issue_lo)
      ,.flush_i(flush_lo)
      ,.data_o(data_o)
      ,.v_o(pipe_v_lo)
      ,.miss_o(miss_lo)
      ,.miss_v_o(miss_v_lo)
      ,.miss_busy_i(miss_busy_lo)
      ,.fill_i(fill_lo)
      ,.fill_v_i(fill_v_lo)
      );

   // Result pulse doubles as the queue commit
   assign v_o = pipe_v_lo;

   miss_unit
      miss
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.miss_i(miss_lo)
      ,.miss_v_i(miss_v_lo)
      ,.miss_busy_o(miss_busy_lo)
      ,.mem_cmd_o(mem_cmd_o)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.mem_resp_i(mem_resp_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_yumi_o(mem_resp_yumi_o)
      ,.fill_o(fill_lo)
      ,.fill_v_o(fill_v_lo)
      );

endmodule

`default_nettype wire

// ==== tests/dcache_replay_sva.sv ====
/*
 * Protocol assertions on the memory and result ports of the cache,
 * bound into the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_replay_sva
   (input  logic                 clk_i
   ,input  logic                 rst_i
   ,input  logic                 res_v_i
   ,input  dcache_pkg::mem_cmd_t mem_cmd_i
   ,input  logic                 mem_cmd_v_i
   ,input  logic                 mem_cmd_ready_i
   ,input  logic                 mem_resp_v_i
   ,input  logic                 mem_resp_yumi_i
   );

   int unsigned assert_fails = 0;

   // Command held until memory takes it
   cmd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (mem_cmd_v_i && !mem_cmd_ready_i) |=> (mem_cmd_v_i && $stable(mem_cmd_i)))
      else
      begin
         $error("memory command dropped or changed while stalled");
         assert_fails++;
      end

   no_result_in_reset: assert property (@(posedge clk_i)
      rst_i |-> (res_v_i !== 1'b1))
      else
      begin
         $error("result valid while in reset");
         assert_fails++;
      end

   // Only one read is ever outstanding, so a response is taken as soon as it shows
   resp_taken_when_valid: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_resp_yumi_i == mem_resp_v_i)
      else
      begin
         $error("response consumed without a valid response, or left waiting");
         assert_fails++;
      end

endmodule

bind dcache_replay_top dcache_replay_sva i_sva
   (.clk_i(clk_i)
   ,.rst_i(rst_i)
   ,.res_v_i(v_o)
   ,.mem_cmd_i(mem_cmd_o)
   ,.mem_cmd_v_i(mem_cmd_v_o)
   ,.mem_cmd_ready_i(mem_cmd_ready_i)
   ,.mem_resp_v_i(mem_resp_v_i)
   ,.mem_resp_yumi_i(mem_resp_yumi_o)
   );

`default_nettype wire

// ==== tests/tb_checker.sv ====
/*
 * Result checker. Predicts each accepted request from a reference memory
 * image and compares results and write-through commands in request order.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_checker
   (input  logic                    clk_i
   ,input  logic                    rst_i
   ,input  dcache_pkg::dcache_pkt_t pkt_i
   ,input  dcache_pkg::ptag_t       ptag_i
   ,input  logic                    req_v_i
   ,input  logic                    req_ready_i
   ,input  logic [95:0]             name_i
   ,input  dcache_pkg::word_t       res_data_i
   ,input  logic                    res_v_i
   ,input  dcache_pkg::mem_cmd_t    mem_cmd_i
   ,input  logic                    mem_cmd_v_i
   ,input  logic                    mem_cmd_ready_i
   ,output int unsigned             results_o
   ,output int unsigned             errors_o
   );

   import dcache_pkg::*;

   paddr_t      ref_addrs [$];
   word_t       ref_vals  [$];
   logic [95:0] name_q    [$];
   word_t       exp_q     [$];
   logic [95:0] wr_name_q [$];
   paddr_t      wr_addr_q [$];
   word_t       wr_data_q [$];
   logic        seen_req;

   // Untouched words hold their byte address XOR 5a5a0000
   function automatic word_t ref_read(paddr_t addr);
      word_t val;
      val = addr ^ 32'h5a5a0000;
      foreach (ref_addrs[k])
         if (ref_addrs[k] == addr)
            val = ref_vals[k];
      return val;
   endfunction

   task automatic note_error(input string msg);
      $display("ERROR: %s", msg);
      errors_o++;
   endtask

   initial
   begin
      results_o = 0;
      errors_o  = 0;
      seen_req  = 1'b0;
   end

   always @(negedge clk_i)
   begin : watch
      paddr_t      addr;
      paddr_t      wr_addr;
      word_t       exp;
      word_t       wr_data;
      logic [95:0] name;

      if (rst_i === 1'b1)
      begin
         if (res_v_i === 1'b1)
            note_error("result valid while in reset");
      end
      else if (rst_i === 1'b0)
      begin
         if (!seen_req && !req_v_i &&
             (req_ready_i !== 1'b1 || res_v_i !== 1'b0 || mem_cmd_v_i !== 1'b0))
            note_error("cache not idle after reset");

         if (req_v_i && req_ready_i)
         begin
            seen_req = 1'b1;
            addr = {ptag_i, pkt_i.offset[11:2], 2'b00};
            name_q.push_back(name_i);
            if (pkt_i.opcode == e_op_store)
            begin
               exp_q.push_back(32'h0);
               ref_addrs.push_back(addr);
               ref_vals.push_back(pkt_i.data);
               wr_name_q.push_back(name_i);
               wr_addr_q.push_back(addr);
               wr_data_q.push_back(pkt_i.data);
            end
            else
               exp_q.push_back(ref_read(addr));
         end

         if (res_v_i)
         begin
            if (exp_q.size() == 0)
               note_error("result with no outstanding request");
            else
            begin
               exp  = exp_q.pop_front();
               name = name_q.pop_front();
               results_o++;
               if (res_data_i === exp)
                  $display("[PASS] %0s: %h", name, res_data_i);
               else
               begin
                  $display("[FAIL] %0s: expected %h, actual %h", name, exp, res_data_i);
                  errors_o++;
               end
            end
         end

         if (mem_cmd_v_i && mem_cmd_ready_i && mem_cmd_i.op == e_mem_write)
         begin
            if (wr_addr_q.size() == 0)
               note_error("memory write with no store outstanding");
            else
            begin
               name    = wr_name_q.pop_front();
               wr_addr = wr_addr_q.pop_front();
               wr_data = wr_data_q.pop_front();
               if (mem_cmd_i.addr !== wr_addr || mem_cmd_i.data !== wr_data)
               begin
                  $display("[FAIL] %0s write: expected %h at %h, actual %h at %h",
                           name, wr_data, wr_addr, mem_cmd_i.data, mem_cmd_i.addr);
                  errors_o++;
               end
            end
         end
      end
   end

   task automatic final_check();
      if (exp_q.size() != 0)
         note_error("some accepted requests never produced a result");
      if (wr_addr_q.size() != 0)
         note_error("some stores never reached memory");
   endtask

endmodule

`default_nettype wire

// ==== tests/tb_top.sv ====
/*
 * Testbench for the replay-queued data cache. Applies a request table,
 * models memory with random back-pressure and hands results to the checker.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

   import dcache_pkg::*;

   typedef logic [8*12-1:0] name_t;

   typedef struct packed
   {
      name_t        name;
      dcache_op_e   op;
      ptag_t        ptag;
      page_offset_t offset;
      word_t        data;
   } test_vec_t;

   logic        clk_i;
   logic        rst_i;
   dcache_pkt_t pkt_i;
   ptag_t       ptag_i;
   logic        v_i;
   logic        ready_o;
   word_t       data_o;
   logic        v_o;
   mem_cmd_t    mem_cmd_o;
   logic        mem_cmd_v_o;
   logic        mem_cmd_ready_i;
   mem_resp_t   mem_resp_i;
   logic        mem_resp_v_i;
   logic        mem_resp_yumi_o;

   name_t       cur_name;
   test_vec_t   tests [$];
   logic        table_ready;
   int unsigned results;
   int unsigned errors;
   int unsigned total_errors;

   paddr_t      mem_addrs [$];
   word_t       mem_vals  [$];

   dcache_replay_top
      #(.fifo_els_p(8)
       ,.sets_p(16))
      i_dut
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.pkt_i(pkt_i)
      ,.ptag_i(ptag_i)
      ,.v_i(v_i)
      ,.ready_o(ready_o)
      ,.data_o(data_o)
      ,.v_o(v_o)
      ,.mem_cmd_o(mem_cmd_o)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.mem_resp_i(mem_resp_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_yumi_o(mem_resp_yumi_o)
      );

   tb_checker
      i_checker
      (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.pkt_i(pkt_i)
      ,.ptag_i(ptag_i)
      ,.req_v_i(v_i)
      ,.req_ready_i(ready_o)
      ,.name_i(cur_name)
      ,.res_data_i(data_o)
      ,.res_v_i(v_o)
      ,.mem_cmd_i(mem_cmd_o)
      ,.mem_cmd_v_i(mem_cmd_v_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.results_o(results)
      ,.errors_o(errors)
      );

   function automatic word_t mem_read_word(paddr_t addr);
      word_t val;
      val = addr ^ 32'h5a5a0000;
      foreach (mem_addrs[k])
         if (mem_addrs[k] == addr)
            val = mem_vals[k];
      return val;
   endfunction

   function automatic block_t mem_read_block(paddr_t addr);
      block_t blk;
      paddr_t base;
      base = {addr[31:4], 4'b0000};
      for (int w = 0; w < 4; w++)
         blk[w*32 +: 32] = mem_read_word(base + 4*w);
      return blk;
   endfunction

   task automatic add_test(input name_t name, input dcache_op_e op, input ptag_t ptag,
                           input page_offset_t offset, input word_t data);
      test_vec_t t;
      t.name   = name;
      t.op     = op;
      t.ptag   = ptag;
      t.offset = offset;
      t.data   = data;
      tests.push_back(t);
   endtask

   task automatic build_table();
      // Cold miss, then same block, store and reload
      add_test("ld_cold0",    e_op_load,  20'h00010, 12'h040, 32'h0);
      add_test("ld_same_blk", e_op_load,  20'h00010, 12'h048, 32'h0);
      add_test("st_word",     e_op_store, 20'h00010, 12'h044, 32'hcafef00d);
      add_test("ld_after_st", e_op_load,  20'h00010, 12'h044, 32'h0);
      add_test("ld_cold1",    e_op_load,  20'h00010, 12'h054, 32'h0);
      // Miss on set 0 with hits to sets 4 and 5 behind it
      add_test("ld_miss_s0",  e_op_load,  20'h00020, 12'h10c, 32'h0);
      add_test("hit_s4",      e_op_load,  20'h00010, 12'h04c, 32'h0);
      add_test("hit_s5",      e_op_load,  20'h00010, 12'h050, 32'h0);
      add_test("hit_s4_st",   e_op_load,  20'h00010, 12'h044, 32'h0);
      add_test("st_miss",     e_op_store, 20'h00030, 12'h0a8, 32'h12345678);
      add_test("ld_st_miss",  e_op_load,  20'h00030, 12'h0a8, 32'h0);
      // Eviction, then reload of the written-through word
      add_test("ld_evict",    e_op_load,  20'h00040, 12'h044, 32'h0);
      add_test("ld_back",     e_op_load,  20'h00010, 12'h044, 32'h0);
      // Burst deeper than the queue
      add_test("burst_ld0",   e_op_load,  20'h00050, 12'h200, 32'h0);
      add_test("burst_st1",   e_op_store, 20'h00050, 12'h204, 32'ha5a5a5a5);
      add_test("burst_ld2",   e_op_load,  20'h00050, 12'h204, 32'h0);
      add_test("burst_ld3",   e_op_load,  20'h00051, 12'h3f0, 32'h0);
      add_test("burst_st4",   e_op_store, 20'h00051, 12'h3f8, 32'h0badcafe);
      add_test("burst_ld5",   e_op_load,  20'h00051, 12'h3f8, 32'h0);
      add_test("burst_ld6",   e_op_load,  20'h00052, 12'h060, 32'h0);
      add_test("burst_ld7",   e_op_load,  20'h00052, 12'h064, 32'h0);
      add_test("burst_st8",   e_op_store, 20'h00052, 12'h068, 32'h13579bdf);
      add_test("burst_ld9",   e_op_load,  20'h00050, 12'h208, 32'h0);
      add_test("burst_ld10",  e_op_load,  20'h00052, 12'h068, 32'h0);
      add_test("burst_ld11",  e_op_load,  20'h00020, 12'h10c, 32'h0);
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial
   begin : stimulus
      rst_i       = 1'b1;
      v_i         = 1'b0;
      pkt_i       = '0;
      ptag_i      = '0;
      cur_name    = '0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      // Idle cycles let the checker see the post-reset state
      repeat (3) @(posedge clk_i);
      #1;
      foreach (tests[i])
      begin
         pkt_i.opcode = tests[i].op;
         pkt_i.offset = tests[i].offset;
         pkt_i.data   = tests[i].data;
         ptag_i       = tests[i].ptag;
         cur_name     = tests[i].name;
         v_i          = 1'b1;
         @(negedge clk_i);
         while (!ready_o)
            @(negedge clk_i);
         @(posedge clk_i);
         #1;
      end
      v_i = 1'b0;
      while (results < tests.size())
         @(negedge clk_i);
      // Extra results would show up here
      repeat (20) @(negedge clk_i);
      i_checker.final_check();
      @(negedge clk_i);
      total_errors = errors + i_dut.i_sva.assert_fails;
      $display("tests %0d, results %0d, errors %0d", tests.size(), results, total_errors);
      if (total_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin : mem_model
      logic        cmd_fire;
      logic        resp_fire;
      logic        pending;
      mem_cmd_t    cmd;
      paddr_t      read_addr;
      int unsigned delay;

      void'($urandom(32'hae1a));
      mem_cmd_ready_i = 1'b0;
      mem_resp_v_i    = 1'b0;
      mem_resp_i      = '0;
      pending         = 1'b0;
      read_addr       = '0;
      delay           = 0;
      forever
      begin
         @(negedge clk_i);
         cmd_fire  = mem_cmd_v_o & mem_cmd_ready_i & ~rst_i;
         resp_fire = mem_resp_v_i & mem_resp_yumi_o;
         cmd       = mem_cmd_o;
         @(posedge clk_i);
         #1;
         mem_cmd_ready_i = ($urandom_range(3, 0) != 0);
         if (resp_fire)
            mem_resp_v_i = 1'b0;
         if (pending)
         begin
            if (delay > 1)
               delay--;
            else
            begin
               mem_resp_i.data = mem_read_block(read_addr);
               mem_resp_v_i    = 1'b1;
               pending         = 1'b0;
            end
         end
         if (cmd_fire)
         begin
            if (cmd.op == e_mem_write)
            begin
               mem_addrs.push_back({cmd.addr[31:2], 2'b00});
               mem_vals.push_back(cmd.data);
            end
            else
            begin
               read_addr = cmd.addr;
               delay     = $urandom_range(4, 1);
               pending   = 1'b1;
            end
         end
      end
   end

   initial
   begin : watchdog
      wait (table_ready === 1'b1);
      repeat (tests.size() * 200) @(posedge clk_i);
      $display("Timeout: requests still outstanding after %0d cycles", tests.size() * 200);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/dcache_pkg.sv
verilog/replay_fifo.sv
verilog/dcache_pipe.sv
verilog/miss_unit.sv
verilog/dcache_replay_top.sv
tests/dcache_replay_sva.sv
tests/tb_checker.sv
tests/tb_top.sv
